/* hdl/ltc2195_pkg.sv */
// Shared definitions for the LTC2195 control path
// Host commands are 16-bit address/data pairs, the upper address byte selects the target
// SPI frames are write-only, the read flag is always zero
// Phase values are fine phase-shift steps of the external clock manager
// The SPI timing is in clk_in cycles, so sck follows the clk_in frequency
`default_nettype none

package ltc2195_pkg;

	////////////////////////////////////////////////////////////
	// Host command interface

	typedef logic [15:0] cmd_addr_t;	// Host command address
	typedef logic [15:0] cmd_data_t;	// Host command data

	localparam logic [7:0] CMD_PREFIX_SPI_SET = 8'h31;	// Write one ADC register
	localparam logic [7:0] CMD_PREFIX_PHASE   = 8'h32;	// New encode phase target

	////////////////////////////////////////////////////////////
	// ADC register access

	typedef logic [6:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Frame as shifted out, MSB first
	typedef struct packed {
		logic      rd_flag;	// Zero for a write
		reg_addr_t reg_addr;
		reg_data_t reg_data;
	} spi_frame_t;

	localparam int SPI_HALF_PERIOD = 5;	// clk_in cycles per sck half period
	localparam int SPI_FRAME_BITS  = 16;

	// Power-up configuration
	localparam int POWERUP_WAIT = 255;	// Cycles before the first frame
	localparam int INIT_COUNT   = 3;

	localparam spi_frame_t INIT_FRAMES [INIT_COUNT] = '{
		'{rd_flag: 1'b0, reg_addr: 7'h00, reg_data: 8'h80},	// Software reset
		'{rd_flag: 1'b0, reg_addr: 7'h01, reg_data: 8'h20},	// Two's complement output
		'{rd_flag: 1'b0, reg_addr: 7'h02, reg_data: 8'h00}	// Two-lane output mode
	};

	////////////////////////////////////////////////////////////
	// Encode clock phase

	typedef logic [8:0] phase_t;	// Position or target in fine steps

	localparam phase_t PHASE_RESET_VALUE  = 9'd256;	// Position after reset
	localparam phase_t PHASE_RESET_TARGET = 9'd380;	// 256 + 124 steps

	////////////////////////////////////////////////////////////
	// State machines

	typedef enum logic [2:0] {
		WAIT,	// Power-up delay
		LOAD,	// Fetch next init frame
		START,	// Launch when the master is free
		BUSY,	// Frame on the wire
		IDLE	// Accept user writes
	} cfg_state_t;

	typedef enum logic [2:0] {
		DECIDE,		// Compare position with target
		ARM,		// Enable pulse on the wire
		PULSE,		// Phase clock high
		WAIT_DONE,	// Toggle phase clock until done
		COUNT		// Step taken
	} phase_state_t;

endpackage

`default_nettype wire

/* hdl/ltc2195_cmd_decode.sv */
// Host command decoder for the LTC2195 controller
// Strobes come one cycle after cmd_trig, with their payload in the same cycle
// Payload only changes on a command with a known prefix
// Unknown prefixes are dropped silently
`timescale 1ns/1ps
`default_nettype none

module ltc2195_cmd_decode (
	input  wire                     clk_in,
	input  wire                     rst_in,
	input  wire                     cmd_trig,
	input  ltc2195_pkg::cmd_addr_t  cmd_addr,
	input  ltc2195_pkg::cmd_data_t  cmd_data,
	output logic                    spi_set,	// One-cycle register write request
	output ltc2195_pkg::spi_frame_t user_frame,
	output logic                    phase_set,	// One-cycle new target
	output ltc2195_pkg::phase_t     phase_target
);

	logic hit_spi;
	logic hit_phase;

	// Prefix match on the upper address byte
	assign hit_spi   = cmd_trig && (cmd_addr[15:8] == ltc2195_pkg::CMD_PREFIX_SPI_SET);
	assign hit_phase = cmd_trig && (cmd_addr[15:8] == ltc2195_pkg::CMD_PREFIX_PHASE);

	// Strobes
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			spi_set   <= 1'b0;
			phase_set <= 1'b0;
		end else begin
			spi_set   <= hit_spi;
			phase_set <= hit_phase;
		end
	end

	// Payload, valid with its strobe
	always_ff @(posedge clk_in) begin
		if (hit_spi) begin
			user_frame.rd_flag  <= 1'b0;	// Writes only
			user_frame.reg_addr <= cmd_addr[6:0];	// Register from address low byte
			user_frame.reg_data <= cmd_data[7:0];
		end
		if (hit_phase)
			phase_target <= cmd_data[8:0];	// Nine low data bits
	end

endmodule

`default_nettype wire

/* hdl/ltc2195_config_seq.sv */
// ADC configuration sequencer
// After reset it waits POWERUP_WAIT cycles, then writes the INIT_FRAMES table in order
// Once the table is done it forwards user register writes, one frame each
// A user write that arrives before IDLE, or while a frame is running, is lost
// spi_start is only raised while spi_ready is high
`timescale 1ns/1ps
`default_nettype none

module ltc2195_config_seq (
	input  wire                     clk_in,
	input  wire                     rst_in,
	input  wire                     spi_set,	// User write strobe
	input  ltc2195_pkg::spi_frame_t user_frame,
	input  wire                     spi_ready,	// Master idle
	output logic                    spi_start,	// One-cycle launch
	output ltc2195_pkg::spi_frame_t spi_frame
);

	ltc2195_pkg::cfg_state_t state;

	logic [7:0] wait_cnt;	// Power-up delay
	logic [1:0] init_idx;	// Table entry, INIT_COUNT once the table is done
	logic       more_init;	// Another table entry follows
	logic       frame_end;	// Master back to idle after our frame

	assign more_init = init_idx < 2'(ltc2195_pkg::INIT_COUNT - 1);

	// Ready is still high in the start cycle, it falls one cycle later
	assign frame_end = spi_ready && !spi_start;

	////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= ltc2195_pkg::WAIT;
			wait_cnt  <= '0;
			init_idx  <= '0;
			spi_start <= 1'b0;
		end else begin
			case (state)
				ltc2195_pkg::WAIT: begin
					wait_cnt <= wait_cnt + 8'd1;
					if (wait_cnt == 8'(ltc2195_pkg::POWERUP_WAIT - 1))
						state <= ltc2195_pkg::LOAD;
				end

				ltc2195_pkg::LOAD:
					state <= ltc2195_pkg::START;	// Frame register loads below

				ltc2195_pkg::START: begin
					if (spi_ready) begin
						spi_start <= 1'b1;
						state     <= ltc2195_pkg::BUSY;
					end
				end

				ltc2195_pkg::BUSY: begin
					spi_start <= 1'b0;	// Single pulse
					if (frame_end) begin
						if (more_init) begin
							init_idx <= init_idx + 2'd1;
							state    <= ltc2195_pkg::LOAD;
						end else begin
							init_idx <= 2'(ltc2195_pkg::INIT_COUNT);	// Table done
							state    <= ltc2195_pkg::IDLE;
						end
					end
				end

				ltc2195_pkg::IDLE: begin
					if (spi_set)
						state <= ltc2195_pkg::START;	// Frame loaded below
				end

				default:
					state <= ltc2195_pkg::IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Outgoing frame

	// Held from load until the master has captured it
	always_ff @(posedge clk_in) begin
		if (state == ltc2195_pkg::LOAD)
			spi_frame <= ltc2195_pkg::INIT_FRAMES[init_idx];
		else if ((state == ltc2195_pkg::IDLE) && spi_set)
			spi_frame <= user_frame;	// Read flag already zero
	end

endmodule

`default_nettype wire

/* hdl/spi_master.sv */
// SPI master, mode 0, MSB first, SPI_FRAME_BITS bits per frame
// sck runs at clk_in / (2 * SPI_HALF_PERIOD)
// Select falls one cycle after spi_start and rises half a period after the last sck fall
// spi_ready returns one cycle after select rises
// Write only, there is no receive path
`timescale 1ns/1ps
`default_nettype none

module spi_master (
	input  wire                     clk_in,
	input  wire                     rst_in,
	input  wire                     spi_start,	// Captures spi_frame when ready
	input  ltc2195_pkg::spi_frame_t spi_frame,
	output logic                    spi_ready,	// High when idle
	output logic                    spi_scs,	// Active low select
	output logic                    spi_sck,
	output logic                    spi_sdo
);

	logic [$clog2(ltc2195_pkg::SPI_HALF_PERIOD)-1:0] div_cnt;	// Half-period divider
	logic [$clog2(ltc2195_pkg::SPI_FRAME_BITS)-1:0]  bit_cnt;	// Bits sent
	logic [ltc2195_pkg::SPI_FRAME_BITS-1:0]          shreg;

	logic shifting;	// sck running
	logic tail;	// Hold select low after the last bit
	logic half_end;
	logic last_bit;
	logic launch;

	assign half_end = div_cnt == $bits(div_cnt)'(ltc2195_pkg::SPI_HALF_PERIOD - 1);
	assign last_bit = bit_cnt == $bits(bit_cnt)'(ltc2195_pkg::SPI_FRAME_BITS - 1);
	assign launch   = spi_ready && spi_start;

	assign spi_sdo = shreg[ltc2195_pkg::SPI_FRAME_BITS-1];	// MSB first

	////////////////////////////////////////////////////////////
	// Frame timing

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			spi_ready <= 1'b1;
			spi_scs   <= 1'b1;
			spi_sck   <= 1'b0;
			shifting  <= 1'b0;
			tail      <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
		end else if (spi_ready) begin
			if (spi_start) begin
				spi_ready <= 1'b0;
				spi_scs   <= 1'b0;	// First bit already on sdo
				shifting  <= 1'b1;
				div_cnt   <= '0;
				bit_cnt   <= '0;
			end
		end else if (shifting) begin
			if (half_end) begin
				div_cnt <= '0;
				spi_sck <= ~spi_sck;
				if (spi_sck) begin	// Falling edge
					if (last_bit) begin
						shifting <= 1'b0;
						tail     <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end else if (tail) begin
			if (half_end) begin
				tail    <= 1'b0;
				spi_scs <= 1'b1;	// End of frame
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end else begin
			spi_ready <= 1'b1;	// One cycle after select rises
		end
	end

	////////////////////////////////////////////////////////////
	// Data path

	// sdo moves only on a falling sck, so it is stable while sck is high
	always_ff @(posedge clk_in) begin
		if (launch)
			shreg <= spi_frame;
		else if (shifting && half_end && spi_sck && !last_bit)
			shreg <= {shreg[ltc2195_pkg::SPI_FRAME_BITS-2:0], 1'b0};
	end

endmodule

`default_nettype wire

/* hdl/phase_step_ctrl.sv */
// Fine phase-shift stepper for an external clock manager
// Steps the position one at a time toward the target, up or down
// A step starts only while ps_locked is high, then waits for ps_done however long it takes
// ps_value follows the manager and changes in the cycle after ps_done
// A new target is taken at any time, a step in progress still finishes
`timescale 1ns/1ps
`default_nettype none

module phase_step_ctrl (
	input  wire                 clk_in,
	input  wire                 rst_in,
	input  wire                 phase_set,	// Target update strobe
	input  ltc2195_pkg::phase_t phase_target,
	input  wire                 ps_done,	// Step finished
	input  wire                 ps_locked,
	output logic                ps_clk,
	output logic                ps_en,
	output logic                ps_incdec,	// 1 for up, 0 for down
	output ltc2195_pkg::phase_t ps_value	// Current position
);

	ltc2195_pkg::phase_state_t state;
	ltc2195_pkg::phase_t       target;

	logic step_up;
	logic need_step;

	assign step_up   = target > ps_value;
	assign need_step = target != ps_value;

	////////////////////////////////////////////////////////////
	// Target

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			target <= ltc2195_pkg::PHASE_RESET_TARGET;
		else if (phase_set)
			target <= phase_target;
	end

	////////////////////////////////////////////////////////////
	// Step machine

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= ltc2195_pkg::DECIDE;
			ps_value  <= ltc2195_pkg::PHASE_RESET_VALUE;
			ps_clk    <= 1'b0;
			ps_en     <= 1'b0;
			ps_incdec <= 1'b0;
		end else begin
			case (state)
				ltc2195_pkg::DECIDE: begin
					// No step without lock
					if (ps_locked && need_step) begin
						ps_en     <= 1'b1;
						ps_incdec <= step_up;	// Kept for the count
						state     <= ltc2195_pkg::ARM;
					end
				end

				ltc2195_pkg::ARM: begin
					ps_en  <= 1'b0;	// Enable lasts one cycle
					ps_clk <= 1'b1;
					state  <= ltc2195_pkg::PULSE;
				end

				ltc2195_pkg::PULSE: begin
					ps_clk <= 1'b0;
					state  <= ltc2195_pkg::WAIT_DONE;
				end

				ltc2195_pkg::WAIT_DONE: begin
					if (ps_done) begin
						// Position follows the manager
						if (ps_incdec)
							ps_value <= ps_value + 9'd1;
						else
							ps_value <= ps_value - 9'd1;
						state <= ltc2195_pkg::COUNT;
					end else begin
						ps_clk <= ~ps_clk;	// Keep the phase clock running
					end
				end

				ltc2195_pkg::COUNT: begin
					ps_clk <= 1'b0;	// Park low before the next decision
					state  <= ltc2195_pkg::DECIDE;
				end

				default:
					state <= ltc2195_pkg::DECIDE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/ltc2195_ctrl.sv */
// LTC2195 ADC control path, top level
// Host commands 0x31xx write an ADC register, 0x32xx set the encode phase target
// The clock manager sits outside, its phase-shift pins are top-level ports
// spi_sdi is kept for pin compatibility only, nothing is read back
// No sample path, the deserialiser side is not part of this block
`timescale 1ns/1ps
`default_nettype none

module ltc2195_ctrl (
	input  wire                    clk_in,
	input  wire                    rst_in,
	// Host command port
	input  wire                    cmd_trig,
	input  ltc2195_pkg::cmd_addr_t cmd_addr,
	input  ltc2195_pkg::cmd_data_t cmd_data,
	// ADC SPI
	output wire                    spi_scs,
	output wire                    spi_sck,
	output wire                    spi_sdo,
	input  wire                    spi_sdi,
	// Clock manager phase shift
	output wire                    ps_clk,
	output wire                    ps_en,
	output wire                    ps_incdec,
	input  wire                    ps_done,
	input  wire                    ps_locked,
	output ltc2195_pkg::phase_t    ps_value
);

	logic                    spi_set;
	logic                    phase_set;
	logic                    spi_start;
	logic                    spi_ready;
	ltc2195_pkg::spi_frame_t user_frame;
	ltc2195_pkg::spi_frame_t spi_frame;
	ltc2195_pkg::phase_t     phase_target;

	////////////////////////////////////////////////////////////
	// Decode, execute and SPI output

	ltc2195_cmd_decode u_decode (
		.clk_in(clk_in), .rst_in(rst_in),
		.cmd_trig(cmd_trig), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.spi_set(spi_set), .user_frame(user_frame),
		.phase_set(phase_set), .phase_target(phase_target)
	);

	ltc2195_config_seq u_cfg (
		.clk_in(clk_in), .rst_in(rst_in),
		.spi_set(spi_set), .user_frame(user_frame), .spi_ready(spi_ready),
		.spi_start(spi_start), .spi_frame(spi_frame)
	);

	spi_master u_spi (
		.clk_in(clk_in), .rst_in(rst_in),
		.spi_start(spi_start), .spi_frame(spi_frame), .spi_ready(spi_ready),
		.spi_scs(spi_scs), .spi_sck(spi_sck), .spi_sdo(spi_sdo)
	);

	phase_step_ctrl u_phase (
		.clk_in(clk_in), .rst_in(rst_in),
		.phase_set(phase_set), .phase_target(phase_target),
		.ps_done(ps_done), .ps_locked(ps_locked),
		.ps_clk(ps_clk), .ps_en(ps_en), .ps_incdec(ps_incdec), .ps_value(ps_value)
	);

endmodule

`default_nettype wire

/* tb/ltc2195_ctrl_chk.sv */
// Protocol checks for the LTC2195 control path, bound into every ltc2195_ctrl
// All properties sample on clk_in and are off while rst_in is high
// violations counts failed checks so the testbench can fold them into its result
`timescale 1ns/1ps
`default_nettype none

module ltc2195_ctrl_chk (
	input wire clk_in,
	input wire rst_in,
	input wire spi_scs,
	input wire spi_sck,
	input wire spi_sdo,
	input wire ps_en,
	input wire ps_locked
);

	int violations = 0;	// Failed checks so far

	////////////////////////////////////////////////////////////
	// SPI pins

	// sck parked low outside a frame
	sck_low_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_scs |-> !spi_sck)
		else begin
			$error("sck high while select is high");
			violations++;
		end

	// Mode 0, data only moves on the falling edge
	sdo_stable_sck_high: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_sck |-> $stable(spi_sdo))
		else begin
			$error("sdo changed while sck is high");
			violations++;
		end

	////////////////////////////////////////////////////////////
	// Phase-shift pins

	ps_en_single_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
		ps_en |=> !ps_en)
		else begin
			$error("ps_en high for two cycles in a row");
			violations++;
		end

	// Step decision is taken on the lock seen one cycle earlier
	ps_en_needs_lock: assert property (@(posedge clk_in) disable iff (rst_in)
		$rose(ps_en) |-> $past(ps_locked))
		else begin
			$error("ps_en rose without lock");
			violations++;
		end

endmodule

bind ltc2195_ctrl ltc2195_ctrl_chk chk (
	.clk_in(clk_in),
	.rst_in(rst_in),
	.spi_scs(spi_scs),
	.spi_sck(spi_sck),
	.spi_sdo(spi_sdo),
	.ps_en(ps_en),
	.ps_locked(ps_locked)
);

`default_nettype wire

/* tb/ltc2195_ctrl_tb.sv */
// Testbench for the LTC2195 control path
// Frames are captured from the SPI pins on clk_in and compared on the rising select
// The clock manager answers each ps_en with one ps_done, 2 to 9 cycles later
// Done delays come from a 32-bit Galois LFSR, seed 96489, one step per bit
// Expected frames are queued before the command that causes them
`timescale 1ns/1ps
`default_nettype none

module ltc2195_ctrl_tb;

	localparam int TIMEOUT_CYCLES = 20000;	// About five times the longest run

	logic clk_in, rst_in, cmd_trig, spi_sdi, ps_done, ps_locked, lock_req;
	ltc2195_pkg::cmd_addr_t cmd_addr;
	ltc2195_pkg::cmd_data_t cmd_data;
	wire spi_scs, spi_sck, spi_sdo, ps_clk, ps_en, ps_incdec;
	ltc2195_pkg::phase_t ps_value;
	ltc2195_pkg::phase_t last_value;
	ltc2195_pkg::phase_t exp_target = 9'd380;	// Last target sent, reset target at first
	ltc2195_pkg::spi_frame_t exp_frames[$];	// Frames still to come, in order
	ltc2195_pkg::spi_frame_t exp_head;

	logic [15:0] shift_reg;	// Captured sdo bits
	logic [31:0] lfsr_state = 32'd96489;
	logic prev_scs = 1'b1;
	logic prev_sck = 1'b0;
	logic prev_ps_clk = 1'b0;
	logic clk_rose = 1'b0;	// Phase clock pulsed since the enable
	int bit_edges, frames_seen, up_count, down_count, en_count, rel_cycles, cycles;
	int first_start = -1;
	int wait_left, err_count, test_errs, tests_run, tests_failed;

	ltc2195_ctrl uut (.*);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);	// Taps 32, 30, 26, 25
	endfunction

	function automatic int draw_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// Write frame layout: read flag, register, value
	function automatic ltc2195_pkg::spi_frame_t expected_frame(input logic [6:0] a,
			input logic [7:0] d);
		ltc2195_pkg::spi_frame_t f;
		f.rd_flag  = 1'b0;
		f.reg_addr = a;
		f.reg_data = d;
		return f;
	endfunction

	task automatic report_fail(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		err_count++;
	endtask

	task automatic end_test(input string name);
		int e;
		e = err_count - test_errs;
		$display("test %-12s %s (%0d errors)", name, (e == 0) ? "ok" : "failed", e);
		tests_run++;
		if (e != 0)
			tests_failed++;
		test_errs = err_count;
	endtask

	task automatic send_cmd(input logic [15:0] addr, input logic [15:0] data);
		@(posedge clk_in);
		cmd_trig <= 1'b1;
		cmd_addr <= addr;
		cmd_data <= data;
		@(posedge clk_in);
		cmd_trig <= 1'b0;
	endtask

	task automatic user_write(input logic [15:0] addr, input logic [15:0] data);
		exp_frames.push_back(expected_frame(addr[6:0], data[7:0]));	// Seven low address bits
		send_cmd(addr, data);
	endtask

	// New phase target, remembered for the direction check
	task automatic set_target(input ltc2195_pkg::phase_t v);
		exp_target = v;
		send_cmd(16'h3200, 16'(v));
	endtask

	// Counters settle by the falling edge
	task automatic wait_frames(input int n);
		while (frames_seen < n)
			@(negedge clk_in);
	endtask

	task automatic wait_value(input ltc2195_pkg::phase_t v);
		while (ps_value != v)
			@(posedge clk_in);
		@(negedge clk_in);
	endtask

	////////////////////////////////////////////////////////////
	// Monitors and clock-manager model

	always @(posedge clk_in) begin
		if (rst_in) begin
			prev_scs = 1'b1;
			prev_sck = 1'b0;
		end else begin
			rel_cycles++;	// Cycles since reset release
			if (!spi_scs && prev_scs) begin	// Select fell
				bit_edges = 0;
				if (first_start < 0)
					first_start = rel_cycles;
			end
			if (!spi_scs && spi_sck && !prev_sck) begin
				shift_reg = {shift_reg[14:0], spi_sdo};
				bit_edges++;
			end
			if (spi_scs && !prev_scs) begin	// End of frame
				assert (bit_edges == 16)
					else report_fail($sformatf("frame had %0d sck edges", bit_edges));
				assert (exp_frames.size() > 0)
					else report_fail($sformatf("unexpected frame %h", shift_reg));
				if (exp_frames.size() > 0) begin
					exp_head = exp_frames.pop_front();
					assert (shift_reg == exp_head)
						else report_fail($sformatf("frame %h, expected %h", shift_reg, exp_head));
				end
				frames_seen++;
			end
			prev_scs = spi_scs;
			prev_sck = spi_sck;
		end
	end

	// Phase position walks in single steps
	always @(posedge clk_in) begin
		if (rst_in) begin
			last_value  = 9'd256;
			prev_ps_clk = 1'b0;
		end else begin
			if (ps_value != last_value) begin
				assert ((ps_value == last_value + 9'd1) || (ps_value == last_value - 9'd1))
					else report_fail($sformatf("ps_value jumped %0d to %0d", last_value, ps_value));
				assert (clk_rose)
					else report_fail("ps_value moved without a ps_clk pulse");
				if (ps_value > last_value)
					up_count++;
				else
					down_count++;
				last_value = ps_value;
				clk_rose   = 1'b0;
			end
			if (ps_en) begin
				en_count++;
				clk_rose = 1'b0;
				// Direction follows the target that was sent
				assert (ps_incdec === (exp_target > last_value))
					else report_fail($sformatf("ps_incdec %b at %0d toward %0d",
						ps_incdec, last_value, exp_target));
			end else if (ps_clk && !prev_ps_clk) begin
				clk_rose = 1'b1;
			end
			prev_ps_clk = ps_clk;
		end
	end

	initial begin : clock_manager_model
		ps_done   = 1'b0;
		ps_locked = 1'b1;
		forever begin
			@(posedge clk_in);
			ps_locked <= lock_req;
			ps_done   <= (wait_left == 1);	// One-cycle done
			if (wait_left != 0)
				wait_left = wait_left - 1;
			else if (ps_en)
				wait_left = 2 + draw_bits(3);	// 2 to 9 cycles
		end
	end

	always @(posedge clk_in) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a wait never completed", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Tests

	initial begin : stimulus
		int f0;
		int e0;
		ltc2195_pkg::phase_t v0;
		rst_in   = 1'b1;
		cmd_trig = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		spi_sdi  = 1'b0;
		lock_req = 1'b1;
		exp_frames.push_back(expected_frame(7'h00, 8'h80));	// Software reset
		exp_frames.push_back(expected_frame(7'h01, 8'h20));	// Two's complement
		exp_frames.push_back(expected_frame(7'h02, 8'h00));	// Two lanes
		repeat (8) @(posedge clk_in);
		rst_in <= 1'b0;
		@(posedge clk_in);
		assert (spi_scs === 1'b1 && spi_sck === 1'b0 && ps_clk === 1'b0 &&
				ps_en === 1'b0 && ps_value == 9'd256)
			else report_fail("outputs not at their reset values after reset");
		wait_frames(3);
		assert (first_start > 255)
			else report_fail($sformatf("first frame started %0d cycles after reset", first_start));
		end_test("power_up");

		user_write(16'h31A5, 16'h003C);	// Register 0x25
		wait_frames(4);
		end_test("user_write");

		wait_value(9'd380);	// Stepping from reset runs by itself
		assert (up_count == 124 && down_count == 0)
			else report_fail($sformatf("%0d up and %0d down steps to 380", up_count, down_count));
		set_target(9'd300);
		wait_value(9'd300);
		assert (down_count == 80 && up_count == 124)
			else report_fail($sformatf("%0d down steps to 300", down_count));
		end_test("phase_step");

		f0 = frames_seen;
		v0 = ps_value;
		e0 = en_count;
		send_cmd(16'h3012, 16'h0155);	// No such prefix
		repeat (300) @(posedge clk_in);
		@(negedge clk_in);
		assert (frames_seen == f0 && ps_value == v0 && en_count == e0)
			else report_fail("unknown prefix caused activity");
		end_test("unknown_cmd");

		@(posedge clk_in);
		lock_req <= 1'b0;
		while (ps_locked)
			@(posedge clk_in);
		e0 = en_count;
		set_target(9'd310);
		repeat (100) @(posedge clk_in);
		@(negedge clk_in);
		assert (en_count == e0 && ps_value == 9'd300)
			else report_fail("phase stepped while unlocked");
		@(posedge clk_in);
		lock_req <= 1'b1;
		wait_value(9'd310);
		assert (up_count == 134)
			else report_fail($sformatf("%0d up steps after relock", up_count - 124));
		end_test("lock_gate");

		// Second write goes out as soon as the first frame has ended
		f0 = frames_seen;
		user_write(16'h3107, 16'h00E1);
		wait_frames(f0 + 1);
		user_write(16'h3108, 16'h001E);
		wait_frames(f0 + 2);
		assert (exp_frames.size() == 0)
			else report_fail($sformatf("%0d frames never arrived", exp_frames.size()));
		end_test("frame_shape");

		$display("Tests run %0d, failed %0d, check errors %0d, protocol violations %0d",
			tests_run, tests_failed, err_count, uut.chk.violations);
		if (err_count == 0 && uut.chk.violations == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/ltc2195_pkg.sv
hdl/ltc2195_cmd_decode.sv
hdl/ltc2195_config_seq.sv
hdl/spi_master.sv
hdl/phase_step_ctrl.sv
hdl/ltc2195_ctrl.sv
tb/ltc2195_ctrl_chk.sv
tb/ltc2195_ctrl_tb.sv

/* Makefile */
# Verilator build for the LTC2195 control path
TOP = ltc2195_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
